//--- flist.f
+incdir+hw
hw/umi_mem_pkg.sv
hw/umi_if.sv
hw/umi_skid.sv
hw/umi_atomic_alu.sv
hw/umi_mem_core.sv
hw/umi_mem_top.sv
verification/umi_mem_clkgen.sv
verification/umi_mem_tb.sv

//--- Bender.yml
package:
  name: umi_mem

sources:
  - include_dirs:
      - hw
    files:
      - hw/umi_mem_pkg.sv
      - hw/umi_if.sv
      - hw/umi_skid.sv
      - hw/umi_atomic_alu.sv
      - hw/umi_mem_core.sv
      - hw/umi_mem_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/umi_mem_clkgen.sv
      - verification/umi_mem_tb.sv

//--- verification/umi_mem_tb.sv
/* testbench for the UMI memory device: stimulus, byte array
   reference model and in-order response checker */

`timescale 1ns/1ps
`include "umi_mem_defs.svh"

module umi_mem_tb;

    logic               clk;
    logic               rst;
    logic               req_valid;
    logic               req_ready;
    logic [`UMI_CW-1:0] req_cmd;
    logic [`UMI_AW-1:0] req_dstaddr;
    logic [`UMI_AW-1:0] req_srcaddr;
    logic [`UMI_DW-1:0] req_data;
    logic               resp_valid;
    logic               resp_ready;
    logic [`UMI_CW-1:0] resp_cmd;
    logic [`UMI_AW-1:0] resp_dstaddr;
    logic [`UMI_AW-1:0] resp_srcaddr;
    logic [`UMI_DW-1:0] resp_data;

    logic [7:0]            model_mem [256];
    umi_mem_pkg::umi_pkt_t exp_q [$];
    logic                  bp_on;

    umi_mem_clkgen umi_mem_clkgen_i (
        .clk (clk),
        .rst (rst)
    );

    umi_mem_top umi_mem_top_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_cmd      (req_cmd),
        .req_dstaddr  (req_dstaddr),
        .req_srcaddr  (req_srcaddr),
        .req_data     (req_data),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_cmd     (resp_cmd),
        .resp_dstaddr (resp_dstaddr),
        .resp_srcaddr (resp_srcaddr),
        .resp_data    (resp_data)
    );

    task automatic end_with_failure();
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    // apply one accepted request to the byte model and report whether a response is due
    function automatic logic model_apply(input umi_mem_pkg::umi_pkt_t req,
                                         output umi_mem_pkg::umi_pkt_t expected);
        logic [4:0]  op;
        logic [2:0]  sz;
        logic [7:0]  ln;
        logic [7:0]  base;
        int          nb;
        logic [63:0] old;
        logic [63:0] mask;
        logic [63:0] a_u;
        logic [63:0] b_u;
        logic [63:0] a_s;
        logic [63:0] b_s;
        logic [63:0] res;
        op   = req.cmd[4:0];
        sz   = req.cmd[7:5];
        ln   = req.cmd[15:8];
        base = req.dstaddr[7:0];
        nb   = (op == umi_mem_pkg::req_atomic) ? (1 << sz) : ((ln + 1) << sz);
        old  = '0;
        for (int i = 0; i < nb; i++) begin
            old[i*8 +: 8] = model_mem[(base + i) % 256];
        end
        res = req.data;
        if (op == umi_mem_pkg::req_atomic) begin
            mask = (nb == 8) ? '1 : (64'd1 << (8 * nb)) - 64'd1;
            a_u  = old & mask;
            b_u  = req.data & mask;
            a_s  = a_u[8*nb-1] ? (a_u | ~mask) : a_u;
            b_s  = b_u[8*nb-1] ? (b_u | ~mask) : b_u;
            case (ln)
                8'd0:    res = a_u + b_u;
                8'd1:    res = a_u & b_u;
                8'd2:    res = a_u | b_u;
                8'd3:    res = a_u ^ b_u;
                8'd4:    res = ($signed(a_s) >= $signed(b_s)) ? a_s : b_s;
                8'd5:    res = ($signed(a_s) <= $signed(b_s)) ? a_s : b_s;
                8'd6:    res = (a_u >= b_u) ? a_u : b_u;
                8'd7:    res = (a_u <= b_u) ? a_u : b_u;
                8'd8:    res = req.data;
                default: res = '0;
            endcase
        end
        if (op == umi_mem_pkg::req_write || op == umi_mem_pkg::req_posted ||
            op == umi_mem_pkg::req_atomic) begin
            for (int i = 0; i < nb; i++) begin
                model_mem[(base + i) % 256] = res[i*8 +: 8];
            end
        end
        // opcode 4 answers a write, 2 answers reads and atomics
        expected.cmd     = {req.cmd[31:16], (op == umi_mem_pkg::req_atomic) ? 8'd0 : ln, sz,
                            (op == umi_mem_pkg::req_write) ? 5'd4 : 5'd2};
        expected.dstaddr = req.srcaddr;
        expected.srcaddr = req.dstaddr;
        expected.data    = (op == umi_mem_pkg::req_write) ? '0 : old;
        return op == umi_mem_pkg::req_read || op == umi_mem_pkg::req_write ||
               op == umi_mem_pkg::req_atomic;
    endfunction

    always @(posedge clk) begin : track_requests
        umi_mem_pkg::umi_pkt_t req_pkt;
        umi_mem_pkg::umi_pkt_t exp_pkt;
        if (!rst && req_valid && req_ready) begin
            req_pkt = {req_cmd, req_dstaddr, req_srcaddr, req_data};
            if (model_apply(req_pkt, exp_pkt)) begin
                exp_q.push_back(exp_pkt);
            end
        end
    end

    always @(posedge clk) begin : compare_responses
        umi_mem_pkg::umi_pkt_t exp_pkt;
        if (!rst && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                $display("response at %0d ns arrived with no request waiting for it", $time);
                end_with_failure();
            end else begin
                exp_pkt = exp_q.pop_front();
                check_value("resp_cmd", exp_pkt.cmd, resp_cmd);
                check_value("resp_dstaddr", exp_pkt.dstaddr, resp_dstaddr);
                check_value("resp_srcaddr", exp_pkt.srcaddr, resp_srcaddr);
                check_value("resp_data", exp_pkt.data, resp_data);
            end
        end
    end

    // random stalls on the response side when back-pressure is on
    always @(negedge clk) begin
        resp_ready = bp_on ? 1'($urandom % 2) : 1'b1;
    end

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // random len that keeps the request inside one data word
    function automatic logic [7:0] pick_len(input logic [2:0] size);
        return 8'($urandom % (8 >> size));
    endfunction

    task automatic send_req(input umi_mem_pkg::umi_opcode_e op, input logic [2:0] size,
                            input logic [7:0] len, input logic [7:0] addr,
                            input logic [63:0] data);
        logic [15:0] hi;
        logic [23:0] upper;
        int          waited;
        hi          = 16'($urandom);
        upper       = 24'($urandom);
        req_valid   = 1'b1;
        req_cmd     = umi_mem_pkg::cmd_make(op, size, len, hi);
        req_dstaddr = {upper, addr};
        req_srcaddr = $urandom;
        req_data    = data;
        waited      = 0;
        while (!req_ready) begin
            @(negedge clk);
            waited++;
            if (waited > 100) begin
                $display("req_ready stayed low for 100 cycles, request not accepted");
                end_with_failure();
            end
        end
        @(negedge clk);
    endtask

    task automatic send_random();
        umi_mem_pkg::umi_opcode_e op;
        logic [2:0]               size;
        logic [7:0]               len;
        size = 3'($urandom % 4);
        len  = pick_len(size);
        case ($urandom % 4)
            0:       op = umi_mem_pkg::req_read;
            1:       op = umi_mem_pkg::req_write;
            2:       op = umi_mem_pkg::req_posted;
            default: begin
                op  = umi_mem_pkg::req_atomic;
                len = 8'($urandom % 9);
            end
        endcase
        send_req(op, size, len, 8'($urandom), rand64());
    endtask

    initial begin
        int         waited;
        logic [7:0] addr;
        logic [7:0] addr_list [4];
        logic [63:0] fill;
        void'($urandom(91812));
        req_valid     = 1'b0;
        req_cmd       = '0;
        req_dstaddr   = '0;
        req_srcaddr   = '0;
        req_data      = '0;
        resp_ready    = 1'b0;
        bp_on         = 1'b0;
        addr_list     = '{8'hff, 8'hfc, 8'hf9, 8'h00};

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 50) begin
                $display("reset was never released");
                end_with_failure();
            end
        end while (rst);
        @(negedge clk);
        check_value("resp_valid", 64'd0, resp_valid);
        check_value("req_ready", 64'd1, req_ready);

        // fill the whole array with a pattern of each byte's address
        for (int w = 0; w < 32; w++) begin
            for (int b = 0; b < 8; b++) begin
                fill[b*8 +: 8] = 8'(w * 8 + b) ^ 8'ha5;
            end
            send_req(umi_mem_pkg::req_write, 3'd3, 8'd0, 8'(w * 8), fill);
        end

        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 6; k++) begin
                addr = (k < 4) ? addr_list[k] : 8'($urandom);
                send_req(umi_mem_pkg::req_write, 3'(s), pick_len(3'(s)), addr, rand64());
                send_req(umi_mem_pkg::req_read, 3'(s), pick_len(3'(s)), addr, '0);
            end
        end

        for (int k = 0; k < 8; k++) begin
            addr = 8'($urandom);
            send_req(umi_mem_pkg::req_posted, 3'd3, 8'd0, addr, rand64());
            send_req(umi_mem_pkg::req_read, 3'd3, 8'd0, addr, '0);
        end

        for (int a = 0; a < 9; a++) begin
            for (int s = 0; s < 4; s++) begin
                addr = 8'($urandom);
                send_req(umi_mem_pkg::req_atomic, 3'(s), 8'(a), addr, rand64());
                send_req(umi_mem_pkg::req_read, 3'(s), 8'd0, addr, '0);
            end
        end

        bp_on = 1'b1;
        repeat (200) send_random();
        req_valid = 1'b0;

        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 3000) begin
                $display("%0d expected responses never arrived", exp_q.size());
                end_with_failure();
            end
        end

        // any extra response in this window finds an empty queue
        bp_on = 1'b0;
        repeat (10) @(negedge clk);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- verification/umi_mem_clkgen.sv
/* testbench clock and synchronous reset generator */

`timescale 1ns/1ps

module umi_mem_clkgen (
    output logic clk,
    output logic rst
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset covers 10 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- hw/umi_mem_top.sv
/* top level of the UMI memory device, plain request and
   response ports around input skid, core and output skid */

`timescale 1ns/1ps
`include "umi_mem_defs.svh"

module umi_mem_top (
    input  logic               clk,
    input  logic               rst,

    input  logic               req_valid,
    output logic               req_ready,
    input  logic [`UMI_CW-1:0] req_cmd,
    input  logic [`UMI_AW-1:0] req_dstaddr,
    input  logic [`UMI_AW-1:0] req_srcaddr,
    input  logic [`UMI_DW-1:0] req_data,

    output logic               resp_valid,
    input  logic               resp_ready,
    output logic [`UMI_CW-1:0] resp_cmd,
    output logic [`UMI_AW-1:0] resp_dstaddr,
    output logic [`UMI_AW-1:0] resp_srcaddr,
    output logic [`UMI_DW-1:0] resp_data
);

    umi_if req_in_if ();
    umi_if req_core_if ();
    umi_if resp_core_if ();
    umi_if resp_out_if ();

    // request ports into the input skid
    assign req_in_if.valid       = req_valid;
    assign req_in_if.pkt.cmd     = req_cmd;
    assign req_in_if.pkt.dstaddr = req_dstaddr;
    assign req_in_if.pkt.srcaddr = req_srcaddr;
    assign req_in_if.pkt.data    = req_data;
    assign req_ready             = req_in_if.ready;

    umi_skid req_skid_i (
        .clk (clk),
        .rst (rst),
        .in  (req_in_if),
        .out (req_core_if)
    );

    umi_mem_core umi_mem_core_i (
        .clk  (clk),
        .rst  (rst),
        .req  (req_core_if),
        .resp (resp_core_if)
    );

    umi_skid resp_skid_i (
        .clk (clk),
        .rst (rst),
        .in  (resp_core_if),
        .out (resp_out_if)
    );

    // output skid onto response ports
    assign resp_out_if.ready = resp_ready;
    assign resp_valid        = resp_out_if.valid;
    assign resp_cmd          = resp_out_if.pkt.cmd;
    assign resp_dstaddr      = resp_out_if.pkt.dstaddr;
    assign resp_srcaddr      = resp_out_if.pkt.srcaddr;
    assign resp_data         = resp_out_if.pkt.data;

endmodule

//--- hw/umi_mem_core.sv
/* byte memory array with request decode, writes, reads,
   atomics and registered response forming */

`timescale 1ns/1ps
`include "umi_mem_defs.svh"

module umi_mem_core (
    input  logic    clk,
    input  logic    rst,
    umi_if.receiver req,
    umi_if.sender   resp
);

    localparam int mem_bytes  = 1 << `UMI_MEM_ABITS;
    localparam int word_bytes = `UMI_DW / 8;

    logic [7:0] mem [mem_bytes];

    umi_mem_pkg::umi_opcode_e opcode;
    logic [2:0]                size;
    logic [7:0]                len;
    logic [15:0]               nb;
    logic [`UMI_MEM_ABITS-1:0] base;
    logic                      is_read;
    logic                      is_write;
    logic                      is_posted;
    logic                      is_atomic;
    logic                      accept;
    logic [`UMI_DW-1:0]        old_data;
    logic [`UMI_DW-1:0]        alu_result;
    logic [`UMI_DW-1:0]        wr_data;
    logic [`UMI_CW-1:0]        resp_cmd;

    assign opcode = umi_mem_pkg::cmd_opcode(req.pkt.cmd);
    assign size   = umi_mem_pkg::cmd_size(req.pkt.cmd);
    assign len    = umi_mem_pkg::cmd_len(req.pkt.cmd);
    assign nb     = umi_mem_pkg::nbytes(req.pkt.cmd);
    assign base   = req.pkt.dstaddr[`UMI_MEM_ABITS-1:0];

    assign is_read   = (opcode == umi_mem_pkg::req_read);
    assign is_write  = (opcode == umi_mem_pkg::req_write);
    assign is_posted = (opcode == umi_mem_pkg::req_posted);
    assign is_atomic = (opcode == umi_mem_pkg::req_atomic);

    // stall only while a held response is not taken
    assign req.ready = !resp.valid || resp.ready;
    assign accept    = req.valid && req.ready;

    // old bytes at wrapped addresses, zero past the count
    always_comb begin
        for (int i = 0; i < word_bytes; i++) begin
            if (i < nb) begin
                old_data[i*8 +: 8] = mem[base + `UMI_MEM_ABITS'(i)];
            end else begin
                old_data[i*8 +: 8] = 8'h00;
            end
        end
    end

    umi_atomic_alu umi_atomic_alu_i (
        .mem_val (old_data),
        .operand (req.pkt.data),
        .size    (size),
        .atype   (umi_mem_pkg::umi_atype_e'(len)),
        .result  (alu_result)
    );

    assign wr_data = is_atomic ? alu_result : req.pkt.data;

    always_ff @(posedge clk) begin
        if (accept && (is_write || is_posted || is_atomic)) begin
            for (int i = 0; i < word_bytes; i++) begin
                if (i < nb) begin
                    mem[base + `UMI_MEM_ABITS'(i)] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // atomics answer like reads, with len forced to zero
    assign resp_cmd = umi_mem_pkg::cmd_make(
        is_write ? umi_mem_pkg::resp_write : umi_mem_pkg::resp_read,
        size,
        is_atomic ? 8'd0 : len,
        req.pkt.cmd[`UMI_CW-1:16]
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
        end else if (accept) begin
            // posted writes and unknown opcodes give no response
            resp.valid <= is_read || is_write || is_atomic;
        end else if (resp.ready) begin
            resp.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp.pkt.cmd     <= resp_cmd;
            resp.pkt.dstaddr <= req.pkt.srcaddr;
            resp.pkt.srcaddr <= req.pkt.dstaddr;
            resp.pkt.data    <= is_write ? '0 : old_data;
        end
    end

endmodule

//--- hw/umi_atomic_alu.sv
/* combinational atomic operation with size dependent
   sign and zero extension of both inputs */

`timescale 1ns/1ps
`include "umi_mem_defs.svh"

module umi_atomic_alu (
    input  logic [`UMI_DW-1:0]       mem_val,
    input  logic [`UMI_DW-1:0]       operand,
    input  logic [2:0]               size,
    input  umi_mem_pkg::umi_atype_e  atype,
    output logic [`UMI_DW-1:0]       result
);

    logic [6:0]                shamt;
    logic [`UMI_DW-1:0]        a_u;
    logic [`UMI_DW-1:0]        b_u;
    logic signed [`UMI_DW-1:0] a_s;
    logic signed [`UMI_DW-1:0] b_s;

    // bits above the element width get shifted out
    always_comb begin
        case (size)
            3'd0:    shamt = 7'd56;
            3'd1:    shamt = 7'd48;
            3'd2:    shamt = 7'd32;
            default: shamt = 7'd0;
        endcase
    end

    assign a_u = (mem_val << shamt) >> shamt;
    assign b_u = (operand << shamt) >> shamt;
    assign a_s = $signed(mem_val << shamt) >>> shamt;
    assign b_s = $signed(operand << shamt) >>> shamt;

    always_comb begin
        case (atype)
            umi_mem_pkg::atype_add:  result = a_u + b_u;
            umi_mem_pkg::atype_and:  result = a_u & b_u;
            umi_mem_pkg::atype_or:   result = a_u | b_u;
            umi_mem_pkg::atype_xor:  result = a_u ^ b_u;
            umi_mem_pkg::atype_max:  result = (a_s >= b_s) ? a_s : b_s;
            umi_mem_pkg::atype_min:  result = (a_s <= b_s) ? a_s : b_s;
            umi_mem_pkg::atype_maxu: result = (a_u >= b_u) ? a_u : b_u;
            umi_mem_pkg::atype_minu: result = (a_u <= b_u) ? a_u : b_u;
            umi_mem_pkg::atype_swap: result = operand;
            default:                 result = '0;
        endcase
    end

endmodule

//--- hw/umi_skid.sv
/* two-entry skid buffer, registers one packet stream */

`timescale 1ns/1ps

module umi_skid (
    input  logic    clk,
    input  logic    rst,
    umi_if.receiver in,
    umi_if.sender   out
);

    logic                  main_valid;
    umi_mem_pkg::umi_pkt_t main_pkt;
    logic                  spill_valid;
    umi_mem_pkg::umi_pkt_t spill_pkt;
    logic                  main_free;

    // only a full spill entry stops the input
    assign in.ready  = !spill_valid;
    assign out.valid = main_valid;
    assign out.pkt   = main_pkt;

    // main register empties or drains this cycle
    assign main_free = !main_valid || out.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (main_free) begin
            if (spill_valid) begin
                main_valid  <= 1'b1;
                spill_valid <= 1'b0;
            end else begin
                main_valid <= in.valid;
            end
        end else if (in.valid && in.ready) begin
            // output stalled, park the new packet
            spill_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_pkt <= spill_valid ? spill_pkt : in.pkt;
        end else if (in.valid && in.ready) begin
            spill_pkt <= in.pkt;
        end
    end

endmodule

//--- hw/umi_if.sv
/* valid/ready packet interface with sender and receiver modports */

`timescale 1ns/1ps

interface umi_if;

    logic                  valid;
    logic                  ready;
    umi_mem_pkg::umi_pkt_t pkt;

    // transfer when valid and ready are high on a rising edge;
    // the sender holds valid and pkt until then
    modport sender (
        output valid,
        output pkt,
        input  ready
    );

    modport receiver (
        input  valid,
        input  pkt,
        output ready
    );

endinterface

//--- hw/umi_mem_pkg.sv
/* opcode and atomic type enums, the packet struct
   and command word field helpers */

`include "umi_mem_defs.svh"

package umi_mem_pkg;

    typedef enum logic [4:0] {
        req_read   = 5'd1,
        resp_read  = 5'd2,
        req_write  = 5'd3,
        resp_write = 5'd4,
        req_posted = 5'd5,
        req_atomic = 5'd9
    } umi_opcode_e;

    typedef enum logic [7:0] {
        atype_add  = 8'd0,
        atype_and  = 8'd1,
        atype_or   = 8'd2,
        atype_xor  = 8'd3,
        atype_max  = 8'd4,
        atype_min  = 8'd5,
        atype_maxu = 8'd6,
        atype_minu = 8'd7,
        atype_swap = 8'd8
    } umi_atype_e;

    typedef struct packed {
        logic [`UMI_CW-1:0] cmd;
        logic [`UMI_AW-1:0] dstaddr;
        logic [`UMI_AW-1:0] srcaddr;
        logic [`UMI_DW-1:0] data;
    } umi_pkt_t;

    function automatic umi_opcode_e cmd_opcode(input logic [`UMI_CW-1:0] cmd);
        return umi_opcode_e'(cmd[4:0]);
    endfunction

    function automatic logic [2:0] cmd_size(input logic [`UMI_CW-1:0] cmd);
        return cmd[7:5];
    endfunction

    // also carries the atomic type for atomic requests
    function automatic logic [7:0] cmd_len(input logic [`UMI_CW-1:0] cmd);
        return cmd[15:8];
    endfunction

    function automatic logic [`UMI_CW-1:0] cmd_make(
        input umi_opcode_e  opcode,
        input logic [2:0]   size,
        input logic [7:0]   len,
        input logic [15:0]  hi
    );
        return {hi, len, size, opcode};
    endfunction

    // byte count of a request, atomics always move one element
    function automatic logic [15:0] nbytes(input logic [`UMI_CW-1:0] cmd);
        logic [15:0] count;
        count = (cmd_opcode(cmd) == req_atomic) ? 16'd1 : 16'(cmd_len(cmd)) + 16'd1;
        return count << cmd_size(cmd);
    endfunction

endpackage

//--- hw/umi_mem_defs.svh
/* width and memory size macros for the UMI memory device */

`ifndef UMI_MEM_DEFS_SVH
`define UMI_MEM_DEFS_SVH

// address field width
`define UMI_AW 32

// data field width, one word per request
`define UMI_DW 64

// command word width
`define UMI_CW 32

// byte address bits of the memory array, 256 bytes
`define UMI_MEM_ABITS 8

`endif
